/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // major opcodes, bits [6:0] of the instruction word.
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;

    // load widths.
    localparam logic [2:0] FUNCT3_LB  = 3'b000;
    localparam logic [2:0] FUNCT3_LH  = 3'b001;
    localparam logic [2:0] FUNCT3_LW  = 3'b010;
    localparam logic [2:0] FUNCT3_LBU = 3'b100;
    localparam logic [2:0] FUNCT3_LHU = 3'b101;

    // store widths.
    localparam logic [2:0] FUNCT3_SB = 3'b000;
    localparam logic [2:0] FUNCT3_SH = 3'b001;
    localparam logic [2:0] FUNCT3_SW = 3'b010;

    // branch conditions.
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    // integer operations, shared by the register and immediate forms.
    localparam logic [2:0] FUNCT3_ADD  = 3'b000;
    localparam logic [2:0] FUNCT3_SLL  = 3'b001;
    localparam logic [2:0] FUNCT3_SLT  = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR  = 3'b100;
    localparam logic [2:0] FUNCT3_SR   = 3'b101;
    localparam logic [2:0] FUNCT3_OR   = 3'b110;
    localparam logic [2:0] FUNCT3_AND  = 3'b111;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    typedef enum logic [2:0] {
        ST_FETCH     = 3'd0,
        ST_REG_READ  = 3'd1,
        ST_EXECUTE   = 3'd2,
        ST_MEMORY    = 3'd3,
        ST_REG_WRITE = 3'd4,
        ST_RESET     = 3'd7
    } state_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // the B format shares this split layout.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // the J format scrambles these same upper twenty bits.
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } rv_inst_u;

endpackage

`default_nettype wire

/* verilog/rv_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
    input  rv_pkg::rv_inst_u inst_i,
    output logic [31:0]      imm_o,
    output logic             op_a_pc_o,
    output logic             op_b_imm_o,
    output logic             reg_write_o,
    output logic             is_load_o,
    output logic             is_store_o,
    output logic             is_jump_o,
    output logic             is_branch_o
);

    import rv_pkg::*;

    logic [31:0] imm_i_fmt;
    logic [31:0] imm_s_fmt;
    logic [31:0] imm_b_fmt;
    logic [31:0] imm_u_fmt;
    logic [31:0] imm_j_fmt;

    assign imm_i_fmt = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
    assign imm_s_fmt = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
    assign imm_b_fmt = {{19{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi[6], inst_i.s.imm_lo[0],
                        inst_i.s.imm_hi[5:0], inst_i.s.imm_lo[4:1], 1'b0};
    assign imm_u_fmt = {inst_i.u.imm, 12'h000};
    assign imm_j_fmt = {{11{inst_i.u.imm[19]}}, inst_i.u.imm[19], inst_i.u.imm[7:0],
                        inst_i.u.imm[8], inst_i.u.imm[18:9], 1'b0};

    always_comb begin
        imm_o       = '0;
        op_a_pc_o   = 1'b0;
        op_b_imm_o  = 1'b0;
        reg_write_o = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_jump_o   = 1'b0;
        is_branch_o = 1'b0;

        case (inst_i.r.opcode)
            OPCODE_LOAD: begin
                imm_o       = imm_i_fmt;
                op_b_imm_o  = 1'b1;
                reg_write_o = 1'b1;
                is_load_o   = 1'b1;
            end
            OPCODE_STORE: begin
                imm_o      = imm_s_fmt;
                op_b_imm_o = 1'b1;
                is_store_o = 1'b1;
            end
            OPCODE_BRANCH: begin
                // operands here form the target, the compare uses the registers.
                imm_o       = imm_b_fmt;
                op_a_pc_o   = 1'b1;
                op_b_imm_o  = 1'b1;
                is_branch_o = 1'b1;
            end
            OPCODE_OP_IMM: begin
                imm_o       = imm_i_fmt;
                op_b_imm_o  = 1'b1;
                reg_write_o = 1'b1;
            end
            OPCODE_OP: begin
                reg_write_o = 1'b1;
            end
            OPCODE_LUI: begin
                imm_o       = imm_u_fmt;
                op_b_imm_o  = 1'b1;
                reg_write_o = 1'b1;
            end
            OPCODE_AUIPC: begin
                imm_o       = imm_u_fmt;
                op_a_pc_o   = 1'b1;
                op_b_imm_o  = 1'b1;
                reg_write_o = 1'b1;
            end
            OPCODE_JAL: begin
                imm_o       = imm_j_fmt;
                op_a_pc_o   = 1'b1;
                op_b_imm_o  = 1'b1;
                reg_write_o = 1'b1;
                is_jump_o   = 1'b1;
            end
            OPCODE_JALR: begin
                imm_o       = imm_i_fmt;
                op_b_imm_o  = 1'b1;
                reg_write_o = 1'b1;
                is_jump_o   = 1'b1;
            end
            default: begin
                // unknown opcodes raise nothing and fall through to pc + 4.
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rv_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
    input  rv_pkg::rv_inst_u inst_i,
    input  logic [31:0]      op_a_i,
    input  logic [31:0]      op_b_i,
    input  logic [31:0]      rs2_i,
    input  logic             is_branch_i,
    output logic [31:0]      result_o,
    output logic             take_branch_o
);

    import rv_pkg::*;

    logic [4:0] shamt;
    logic       is_int_op;
    logic       is_sub;
    logic       is_arith_shift;
    logic       cond;

    assign shamt          = op_b_i[4:0];
    assign is_int_op      = (inst_i.r.opcode == OPCODE_OP) || (inst_i.r.opcode == OPCODE_OP_IMM);
    // bit 30 means subtract only in the register form, the immediate form uses it as imm.
    assign is_sub         = (inst_i.r.opcode == OPCODE_OP) && inst_i.r.funct7[5];
    assign is_arith_shift = inst_i.r.funct7[5];

    always_comb begin
        if (is_int_op) begin
            case (inst_i.r.funct3)
                FUNCT3_ADD:  result_o = is_sub ? (op_a_i - op_b_i) : (op_a_i + op_b_i);
                FUNCT3_SLL:  result_o = op_a_i << shamt;
                FUNCT3_SLT:  result_o = {31'b0, $signed(op_a_i) < $signed(op_b_i)};
                FUNCT3_SLTU: result_o = {31'b0, op_a_i < op_b_i};
                FUNCT3_XOR:  result_o = op_a_i ^ op_b_i;
                FUNCT3_SR: begin
                    if (is_arith_shift) begin
                        result_o = $signed(op_a_i) >>> shamt;
                    end else begin
                        result_o = op_a_i >> shamt;
                    end
                end
                FUNCT3_OR:   result_o = op_a_i | op_b_i;
                FUNCT3_AND:  result_o = op_a_i & op_b_i;
                default:     result_o = op_a_i + op_b_i;
            endcase
        end else if (inst_i.r.opcode == OPCODE_LUI) begin
            result_o = op_b_i;
        end else begin
            // addresses, jump and branch targets, auipc.
            result_o = op_a_i + op_b_i;
        end
    end

    always_comb begin
        case (inst_i.r.funct3)
            FUNCT3_BEQ:  cond = (op_a_i == rs2_i);
            FUNCT3_BNE:  cond = (op_a_i != rs2_i);
            FUNCT3_BLT:  cond = ($signed(op_a_i) < $signed(rs2_i));
            FUNCT3_BGE:  cond = ($signed(op_a_i) >= $signed(rs2_i));
            FUNCT3_BLTU: cond = (op_a_i < rs2_i);
            FUNCT3_BGEU: cond = (op_a_i >= rs2_i);
            default:     cond = 1'b0;
        endcase
    end

    assign take_branch_o = is_branch_i && cond;

endmodule

`default_nettype wire

/* verilog/rv_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  logic        clk_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    input  logic [4:0]  rd_i,
    input  logic        we_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // x0 may hold a written value, it is masked on every read.
    assign rdata1_o = (rs1_i == 5'd0) ? 32'h0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == 5'd0) ? 32'h0 : regs[rs2_i];

endmodule

`default_nettype wire

/* verilog/rv_result.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_result (
    input  rv_pkg::rv_inst_u inst_i,
    input  logic [31:0]      addr_i,
    input  logic [31:0]      rs2_data_i,
    input  logic [31:0]      bus_data_i,
    input  logic [31:0]      pc_i,
    input  logic             is_load_i,
    input  logic             is_jump_i,
    output logic [31:0]      store_data_o,
    output logic [3:0]       store_sel_o,
    output logic [31:0]      wb_data_o
);

    import rv_pkg::*;

    logic [1:0]  byte_off;
    logic [31:0] lane_word;
    logic [31:0] load_data;

    assign byte_off = addr_i[1:0];

    always_comb begin
        case (inst_i.s.funct3)
            FUNCT3_SB: begin
                store_data_o = rs2_data_i << {byte_off, 3'b000};
                store_sel_o  = 4'b0001 << byte_off;
            end
            FUNCT3_SH: begin
                store_data_o = rs2_data_i << {byte_off[1], 4'b0000};
                store_sel_o  = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            FUNCT3_SW: begin
                store_data_o = rs2_data_i;
                store_sel_o  = 4'b1111;
            end
            default: begin
                store_data_o = rs2_data_i;
                store_sel_o  = 4'b1111;
            end
        endcase
    end

    // bring the addressed lane down to bit 0.
    assign lane_word = bus_data_i >> {byte_off, 3'b000};

    always_comb begin
        case (inst_i.i.funct3)
            FUNCT3_LB:  load_data = {{24{lane_word[7]}}, lane_word[7:0]};
            FUNCT3_LBU: load_data = {24'h0, lane_word[7:0]};
            FUNCT3_LH:  load_data = {{16{lane_word[15]}}, lane_word[15:0]};
            FUNCT3_LHU: load_data = {16'h0, lane_word[15:0]};
            FUNCT3_LW:  load_data = bus_data_i;
            default:    load_data = bus_data_i;
        endcase
    end

    always_comb begin
        if (is_jump_i) begin
            wb_data_o = pc_i + 32'd4;
        end else if (is_load_i) begin
            wb_data_o = load_data;
        end else begin
            wb_data_o = addr_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [31:0] dat_i,
    input  logic        ack_i,
    output logic [31:0] dat_o,
    output logic [31:0] adr_o,
    output logic [3:0]  sel_o,
    output logic        we_o,
    output logic        stb_o,
    output logic        cyc_o
);

    import rv_pkg::*;

    state_t      state;
    logic [31:0] pc_q;
    rv_inst_u    ir_q;
    logic [31:0] alu_q;
    logic        branch_q;
    logic [31:0] wb_q;

    logic [31:0] imm;
    logic        op_a_pc;
    logic        op_b_imm;
    logic        reg_write;
    logic        is_load;
    logic        is_store;
    logic        is_jump;
    logic        is_branch;
    logic        mem_access;

    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        rf_we;

    logic [31:0] alu_op_a;
    logic [31:0] alu_op_b;
    logic [31:0] alu_result;
    logic        take_branch;

    logic [31:0] store_data;
    logic [3:0]  store_sel;
    logic [31:0] wb_data;
    logic [31:0] pc_next;

    // ########################################
    // sub-blocks
    // ########################################

    rv_decode u_decode (
        .inst_i      (ir_q),
        .imm_o       (imm),
        .op_a_pc_o   (op_a_pc),
        .op_b_imm_o  (op_b_imm),
        .reg_write_o (reg_write),
        .is_load_o   (is_load),
        .is_store_o  (is_store),
        .is_jump_o   (is_jump),
        .is_branch_o (is_branch)
    );

    rv_regfile u_regfile (
        .clk_i    (clk_i),
        .rs1_i    (ir_q.r.rs1),
        .rs2_i    (ir_q.r.rs2),
        .rd_i     (ir_q.r.rd),
        .we_i     (rf_we),
        .wdata_i  (wb_q),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    rv_alu u_alu (
        .inst_i        (ir_q),
        .op_a_i        (alu_op_a),
        .op_b_i        (alu_op_b),
        .rs2_i         (rs2_data),
        .is_branch_i   (is_branch),
        .result_o      (alu_result),
        .take_branch_o (take_branch)
    );

    rv_result u_result (
        .inst_i       (ir_q),
        .addr_i       (alu_q),
        .rs2_data_i   (rs2_data),
        .bus_data_i   (dat_i),
        .pc_i         (pc_q),
        .is_load_i    (is_load),
        .is_jump_i    (is_jump),
        .store_data_o (store_data),
        .store_sel_o  (store_sel),
        .wb_data_o    (wb_data)
    );

    assign mem_access = is_load | is_store;
    assign rf_we      = (state == ST_REG_WRITE) && reg_write;

    // register read feeds the raw registers so the branch compare sees rs1 and rs2.
    // execute then feeds the decoded operands for the result or target.
    always_comb begin
        case (state)
            ST_EXECUTE: begin
                alu_op_a = op_a_pc ? pc_q : rs1_data;
                alu_op_b = op_b_imm ? imm : rs2_data;
            end
            default: begin
                alu_op_a = rs1_data;
                alu_op_b = rs2_data;
            end
        endcase
    end

    // jalr may produce an odd target, bit 0 is dropped.
    always_comb begin
        if (is_jump) begin
            pc_next = {alu_q[31:1], 1'b0};
        end else if (branch_q) begin
            pc_next = alu_q;
        end else begin
            pc_next = pc_q + 32'd4;
        end
    end

    // ########################################
    // sequencing
    // ########################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= ST_RESET;
            pc_q  <= RESET_PC;
        end else begin
            case (state)
                ST_RESET: state <= ST_FETCH;
                ST_FETCH: begin
                    if (ack_i) begin
                        state <= ST_REG_READ;
                    end
                end
                ST_REG_READ: state <= ST_EXECUTE;
                ST_EXECUTE:  state <= ST_MEMORY;
                ST_MEMORY: begin
                    if (!mem_access || ack_i) begin
                        state <= ST_REG_WRITE;
                    end
                end
                ST_REG_WRITE: begin
                    state <= ST_FETCH;
                    pc_q  <= pc_next;
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == ST_FETCH && ack_i) begin
            ir_q <= dat_i;
        end
        if (state == ST_REG_READ) begin
            branch_q <= take_branch;
        end
        if (state == ST_EXECUTE) begin
            alu_q <= alu_result;
        end
        // load data is only valid with ack_i, so the write-back value is held here.
        if (state == ST_MEMORY && (!mem_access || ack_i)) begin
            wb_q <= wb_data;
        end
    end

    // ########################################
    // bus drive
    // ########################################

    always_comb begin
        stb_o = 1'b0;
        we_o  = 1'b0;
        sel_o = 4'b1111;
        adr_o = pc_q;

        case (state)
            ST_FETCH: begin
                stb_o = 1'b1;
            end
            ST_MEMORY: begin
                if (mem_access) begin
                    stb_o = 1'b1;
                    adr_o = {alu_q[31:2], 2'b00};
                    we_o  = is_store;
                    sel_o = is_store ? store_sel : 4'b1111;
                end
            end
            default: begin
                stb_o = 1'b0;
            end
        endcase
    end

    assign cyc_o = stb_o;
    assign dat_o = store_data;

endmodule

`default_nettype wire

/* bench/cpu_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_sva (
    input logic           clk_i,
    input logic           rst_i,
    input rv_pkg::state_t state_i,
    input logic           stb_i,
    input logic           cyc_i,
    input logic           we_i,
    input logic           ack_i,
    input logic [31:0]    adr_i
);

    import rv_pkg::*;

    int unsigned fail_count = 0;

    strobe_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i)
        else begin
            fail_count++;
            $error("stb_o is high without cyc_o");
        end

    // a waiting transfer keeps its address and direction until the acknowledge.
    request_held: assert property (@(posedge clk_i) disable iff (rst_i)
        (stb_i && !ack_i) |=> (stb_i && $stable(adr_i) && $stable(we_i)))
        else begin
            fail_count++;
            $error("bus request changed or dropped before ack_i");
        end

    idle_after_reset: assert property (@(posedge clk_i) rst_i |=> !stb_i)
        else begin
            fail_count++;
            $error("stb_o is high in the cycle after reset");
        end

    data_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        (stb_i && state_i == ST_MEMORY) |-> (adr_i[1:0] == 2'b00))
        else begin
            fail_count++;
            $error("data access address is not word aligned");
        end

endmodule

bind cpu cpu_sva u_sva (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .state_i (state),
    .stb_i   (stb_o),
    .cyc_i   (cyc_o),
    .we_i    (we_o),
    .ack_i   (ack_i),
    .adr_i   (adr_o)
);

`default_nettype wire

/* bench/cpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;

    import rv_pkg::*;

    localparam logic [31:0] RES_BASE  = 32'h0000_0300;
    localparam logic [31:0] DATA_BASE = 32'h0000_0200;

    logic        clk_i;
    logic        rst_i;
    logic [31:0] dat_i;
    logic        ack_i;
    logic [31:0] dat_o;
    logic [31:0] adr_o;
    logic [3:0]  sel_o;
    logic        we_o;
    logic        stb_o;
    logic        cyc_o;

    logic [31:0] mem [0:255];
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_sel [$];
    int unsigned exp_idx;
    int unsigned xfer_count;
    logic [31:0] res_off;
    logic [31:0] marker;
    logic [31:0] halt_addr;
    logic        halt_seen;
    logic        busy;
    int unsigned wait_left;
    int unsigned cycles;
    int unsigned cycle_limit;

    cpu u_dut (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .dat_i (dat_i),
        .ack_i (ack_i),
        .dat_o (dat_o),
        .adr_o (adr_o),
        .sel_o (sel_o),
        .we_o  (we_o),
        .stb_o (stb_o),
        .cyc_o (cyc_o)
    );

    // ########################################
    // failure reporting
    // ########################################

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("error at %0t: %s is %h, expected %h",
                                        $time, name, got, expected));
        end
    endtask

    function automatic logic [31:0] lane_mask(input logic [3:0] sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    // ########################################
    // instruction encoding
    // ########################################

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
    endfunction

    function automatic logic [31:0] next_pc();
        return RESET_PC + 32'(prog.size() * 4);
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic expect_write(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] sel);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_sel.push_back(sel);
    endtask

    // sw rs, res_off(x10) with the word that rs must hold by then.
    task automatic store_result(input logic [4:0] rs, input logic [31:0] expected);
        emit(s_type(res_off[11:0], rs, 5'd10, FUNCT3_SW));
        expect_write(RES_BASE + res_off, expected, 4'hF);
        res_off = res_off + 32'd4;
    endtask

    task automatic alu_reg(input logic [6:0] f7, input logic [2:0] f3,
                           input logic [31:0] expected);
        emit(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
        store_result(5'd3, expected);
    endtask

    task automatic alu_imm(input logic [11:0] imm, input logic [4:0] rs1,
                           input logic [2:0] f3, input logic [31:0] expected);
        emit(i_type(imm, rs1, f3, 5'd3, OPCODE_OP_IMM));
        store_result(5'd3, expected);
    endtask

    task automatic load_case(input logic [11:0] off, input logic [2:0] f3,
                             input logic [31:0] expected);
        emit(i_type(off, 5'd11, f3, 5'd5, OPCODE_LOAD));
        store_result(5'd5, expected);
    endtask

    // a taken branch jumps over the marker store.
    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic taken);
        marker = marker + 32'd1;
        emit(i_type(marker[11:0], 5'd0, FUNCT3_ADD, 5'd6, OPCODE_OP_IMM));
        emit(b_type(13'd8, rs2, rs1, f3));
        emit(s_type(res_off[11:0], 5'd6, 5'd10, FUNCT3_SW));
        if (!taken) begin
            expect_write(RES_BASE + res_off, marker, 4'hF);
        end
        res_off = res_off + 32'd4;
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] p;
        emit(i_type(RES_BASE[11:0], 5'd0, FUNCT3_ADD, 5'd10, OPCODE_OP_IMM));
        emit(i_type(DATA_BASE[11:0], 5'd0, FUNCT3_ADD, 5'd11, OPCODE_OP_IMM));
        emit(i_type(12'hFF9, 5'd0, FUNCT3_ADD, 5'd1, OPCODE_OP_IMM));
        emit(i_type(12'h00C, 5'd0, FUNCT3_ADD, 5'd2, OPCODE_OP_IMM));
        emit(i_type(12'h00C, 5'd0, FUNCT3_ADD, 5'd7, OPCODE_OP_IMM));

        // x1 = -7 and x2 = 12.
        alu_reg(7'h00, FUNCT3_ADD, 32'h0000_0005);
        alu_reg(7'h20, FUNCT3_ADD, 32'hFFFF_FFED);
        alu_reg(7'h00, FUNCT3_AND, 32'h0000_0008);
        alu_reg(7'h00, FUNCT3_OR, 32'hFFFF_FFFD);
        alu_reg(7'h00, FUNCT3_XOR, 32'hFFFF_FFF5);
        alu_reg(7'h00, FUNCT3_SLT, 32'h0000_0001);
        alu_reg(7'h00, FUNCT3_SLTU, 32'h0000_0000);
        alu_reg(7'h00, FUNCT3_SLL, 32'hFFFF_9000);
        alu_reg(7'h00, FUNCT3_SR, 32'h000F_FFFF);
        alu_reg(7'h20, FUNCT3_SR, 32'hFFFF_FFFF);
        alu_imm(12'h064, 5'd1, FUNCT3_ADD, 32'h0000_005D);
        alu_imm(12'h0F0, 5'd1, FUNCT3_XOR, 32'hFFFF_FF09);
        alu_imm(12'hF00, 5'd2, FUNCT3_OR, 32'hFFFF_FF0C);
        alu_imm(12'h0FF, 5'd1, FUNCT3_AND, 32'h0000_00F9);
        alu_imm(12'hFFA, 5'd1, FUNCT3_SLT, 32'h0000_0001);
        alu_imm(12'h00C, 5'd1, FUNCT3_SLTU, 32'h0000_0000);
        alu_imm(12'h01C, 5'd2, FUNCT3_SLL, 32'hC000_0000);
        alu_imm(12'h404, 5'd3, FUNCT3_SR, 32'hFC00_0000);
        alu_imm(12'h01C, 5'd1, FUNCT3_SR, 32'h0000_000F);
        emit({20'hABCDE, 5'd3, OPCODE_LUI});
        store_result(5'd3, 32'hABCD_E000);
        p = next_pc();
        emit({20'h00001, 5'd3, OPCODE_AUIPC});
        store_result(5'd3, p + 32'h0000_1000);

        // byte and halfword stores of x4 = 0x12345678 into each lane.
        emit({20'h12345, 5'd4, OPCODE_LUI});
        emit(i_type(12'h678, 5'd4, FUNCT3_ADD, 5'd4, OPCODE_OP_IMM));
        for (int k = 0; k < 4; k++) begin
            a = res_off + 32'(k);
            emit(s_type(a[11:0], 5'd4, 5'd10, FUNCT3_SB));
            expect_write(RES_BASE + res_off, 32'h78 << (8 * k), 4'b0001 << k);
        end
        res_off = res_off + 32'd4;
        a = res_off + 32'd2;
        emit(s_type(res_off[11:0], 5'd4, 5'd10, FUNCT3_SH));
        expect_write(RES_BASE + res_off, 32'h0000_5678, 4'b0011);
        emit(s_type(a[11:0], 5'd4, 5'd10, FUNCT3_SH));
        expect_write(RES_BASE + res_off, 32'h5678_0000, 4'b1100);
        res_off = res_off + 32'd4;

        // data words are F1E2D3C4 and 7F6E5D4C.
        load_case(12'd0, FUNCT3_LB, 32'hFFFF_FFC4);
        load_case(12'd1, FUNCT3_LBU, 32'h0000_00D3);
        load_case(12'd7, FUNCT3_LB, 32'h0000_007F);
        load_case(12'd2, FUNCT3_LH, 32'hFFFF_F1E2);
        load_case(12'd0, FUNCT3_LHU, 32'h0000_D3C4);
        load_case(12'd6, FUNCT3_LHU, 32'h0000_7F6E);
        load_case(12'd4, FUNCT3_LW, 32'h7F6E_5D4C);

        // x7 equals x2, and x1 is negative but large when unsigned.
        branch_case(FUNCT3_BEQ, 5'd2, 5'd7, 1'b1);
        branch_case(FUNCT3_BEQ, 5'd1, 5'd2, 1'b0);
        branch_case(FUNCT3_BNE, 5'd1, 5'd2, 1'b1);
        branch_case(FUNCT3_BNE, 5'd2, 5'd7, 1'b0);
        branch_case(FUNCT3_BLT, 5'd1, 5'd2, 1'b1);
        branch_case(FUNCT3_BLT, 5'd2, 5'd1, 1'b0);
        branch_case(FUNCT3_BGE, 5'd2, 5'd1, 1'b1);
        branch_case(FUNCT3_BGE, 5'd1, 5'd2, 1'b0);
        branch_case(FUNCT3_BLTU, 5'd2, 5'd1, 1'b1);
        branch_case(FUNCT3_BLTU, 5'd1, 5'd2, 1'b0);
        branch_case(FUNCT3_BGEU, 5'd1, 5'd2, 1'b1);
        branch_case(FUNCT3_BGEU, 5'd2, 5'd1, 1'b0);

        // each jump passes over a store that must never reach the bus.
        p = next_pc();
        emit(j_type(21'd8, 5'd8));
        emit(s_type(12'h000, 5'd1, 5'd10, FUNCT3_SW));
        store_result(5'd8, p + 32'd4);
        p = next_pc();
        emit({20'h00000, 5'd9, OPCODE_AUIPC});
        emit(i_type(12'd13, 5'd9, 3'b000, 5'd12, OPCODE_JALR));
        emit(s_type(12'h000, 5'd1, 5'd10, FUNCT3_SW));
        store_result(5'd12, p + 32'd8);

        halt_addr = next_pc();
        emit(j_type(21'd0, 5'd0));
    endtask

    task automatic load_memory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hC0DE_0000 | 32'(i << 2);
        end
        foreach (prog[k]) begin
            mem[(RESET_PC >> 2) + 32'(k)] = prog[k];
        end
        mem[DATA_BASE >> 2]         = 32'hF1E2_D3C4;
        mem[(DATA_BASE >> 2) + 1]   = 32'h7F6E_5D4C;
    endtask

    // ########################################
    // bus memory model
    // ########################################

    task automatic serve_transfer();
        logic [31:0] mask;
        if (xfer_count == 0) begin
            check_value("adr_o", adr_o, RESET_PC);
            check_value("we_o", {31'h0, we_o}, 32'h0);
        end
        xfer_count++;
        if (adr_o[31:10] != 22'h0) begin
            stop_with_failure($sformatf("bus access to %h lies outside the memory", adr_o));
        end else if (we_o) begin
            if (exp_idx >= exp_addr.size()) begin
                stop_with_failure($sformatf("unexpected store to %h at %0t", adr_o, $time));
            end else begin
                mask = lane_mask(exp_sel[exp_idx]);
                check_value("adr_o", adr_o, exp_addr[exp_idx]);
                check_value("sel_o", {28'h0, sel_o}, {28'h0, exp_sel[exp_idx]});
                check_value("dat_o", dat_o & mask, exp_data[exp_idx] & mask);
                exp_idx++;
                mask = lane_mask(sel_o);
                mem[adr_o[9:2]] = (mem[adr_o[9:2]] & ~mask) | (dat_o & mask);
            end
        end else begin
            check_value("sel_o", {28'h0, sel_o}, 32'h0000_000F);
            dat_i = mem[adr_o[9:2]];
            if (adr_o == halt_addr) begin
                halt_seen = 1'b1;
            end
        end
    endtask

    initial begin
        void'($urandom(74));
        ack_i = 1'b0;
        dat_i = '0;
        busy  = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            if (rst_i || ack_i) begin
                ack_i = 1'b0;
                busy  = 1'b0;
            end else if (stb_o) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = $urandom % 4;
                end
                if (wait_left == 0) begin
                    serve_transfer();
                    ack_i = 1'b1;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    // ########################################
    // clock, reset and run control
    // ########################################

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk_i);
            cycles++;
            if (u_dut.u_sva.fail_count != 0) begin
                stop_with_failure("a bus protocol assertion failed during the run");
            end else if (cycles > cycle_limit) begin
                stop_with_failure($sformatf("program did not reach its end in %0d cycles",
                                            cycle_limit));
            end
        end
    end

    initial begin
        rst_i       = 1'b1;
        exp_idx     = 0;
        xfer_count  = 0;
        res_off     = '0;
        marker      = '0;
        halt_seen   = 1'b0;
        cycle_limit = 100000;
        build_program();
        load_memory();
        cycle_limit = prog.size() * (5 + 2 * 3) + 50;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        wait (halt_seen);
        if (exp_idx != exp_addr.size()) begin
            stop_with_failure($sformatf("only %0d of %0d expected stores appeared",
                                        exp_idx, exp_addr.size()));
        end else if (u_dut.u_sva.fail_count != 0) begin
            stop_with_failure("a bus protocol assertion failed during the run");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* flist.f */
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_result.sv
verilog/cpu.sv
bench/cpu_sva.sv
bench/cpu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -o cpu_sim -f flist.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/cpu_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0
